//--- hdl/core_defs.svh
`ifndef CORE_DEFS_SVH
`define CORE_DEFS_SVH

// reorder buffer entries
// must stay a power of two, the rob tag width is its log2
`define ROB_DEPTH 8

// issue queue slots
`define IQ_DEPTH 4

// architectural integer registers
`define NUM_AREGS 32

`endif

//--- hdl/uop_pkg.sv
`default_nettype none

`include "core_defs.svh"

package uop_pkg;

	// widths derived from the depth defines
	localparam int ROB_TAG_W = $clog2(`ROB_DEPTH);
	localparam int AREG_W = $clog2(`NUM_AREGS);

	typedef logic [ROB_TAG_W-1:0] rob_tag_t;
	typedef logic [AREG_W-1:0] areg_t;

	// source operand, busy until the producer writes back
	typedef struct packed {
		logic busy;
		rob_tag_t tag;
	} src_t;

	// renamed micro-op from the front end
	typedef struct packed {
		logic [31:0] pc;
		areg_t rd;
		logic has_rd;
		src_t src1;
		src_t src2;
		// opaque to this block, decoded in execute
		logic [7:0] op;
	} uop_t;

	// what execute receives
	typedef struct packed {
		uop_t uop;
		rob_tag_t tag;
	} iss_t;

	// retired entry
	typedef struct packed {
		logic [31:0] pc;
		areg_t rd;
		logic has_rd;
		rob_tag_t tag;
	} commit_t;

	// single-cycle writeback broadcast
	typedef struct packed {
		logic valid;
		rob_tag_t tag;
	} wb_t;

endpackage

`default_nettype wire

//--- hdl/pipe_ctl_pkg.sv
`default_nettype none

package pipe_ctl_pkg;

	// per-stage controls
	// f, d and r go to the front end
	typedef struct packed {
		logic stall_f;
		logic stall_d;
		logic stall_r;
		logic flush_d;
		logic flush_r;
		// empties rob and issue queue
		logic flush_q;
	} pipe_ctl_t;

	// occupancy reported by the back end structures
	typedef struct packed {
		logic rob_full;
		logic iq_full;
	} struct_stat_t;

endpackage

`default_nettype wire

//--- hdl/reorder_buffer.sv
`default_nettype none

`include "core_defs.svh"

module reorder_buffer (
	input logic clk,
	input logic rst,
	// allocation side, one uop per accepted beat
	input logic alloc,
	input uop_pkg::uop_t alloc_uop,
	output uop_pkg::rob_tag_t alloc_tag,
	// completion broadcast
	input uop_pkg::wb_t wb,
	input logic flush,
	// in-order retire
	output logic cmt_valid,
	output uop_pkg::commit_t cmt,
	input logic cmt_ready,
	output logic full
);
	import uop_pkg::*;

	localparam int DEPTH = `ROB_DEPTH;

	// pointers carry one wrap bit above the index
	typedef logic [ROB_TAG_W:0] ptr_t;

	ptr_t head;
	ptr_t tail;
	rob_tag_t head_idx;
	logic empty;
	logic cmt_fire;

	// per-entry completion flags
	logic [DEPTH-1:0] done;
	// retire payload, written once at allocation
	commit_t ent [DEPTH];

	assign head_idx = head[ROB_TAG_W-1:0];
	// tail slot is the tag the next uop receives
	assign alloc_tag = tail[ROB_TAG_W-1:0];

	// same index, different lap
	assign full = (head[ROB_TAG_W] != tail[ROB_TAG_W]) && (head_idx == alloc_tag);
	assign empty = (head == tail);

	// oldest entry retires only once written back
	assign cmt_valid = ~empty & done[head_idx];
	// head and done only move on a transfer, so cmt holds under back-pressure
	assign cmt = ent[head_idx];
	assign cmt_fire = cmt_valid & cmt_ready;

	// pointer and completion state
	always_ff @(posedge clk) begin
		if (rst || flush) begin
			head <= '0;
			tail <= '0;
			done <= '0;
		end else begin
			// alloc is already qualified by in_ready, never seen while full
			if (alloc) begin
				tail <= tail + 1'b1;
				done[alloc_tag] <= 1'b0;
			end
			// a fresh entry has not issued yet, so wb never hits the tail slot
			if (wb.valid) begin
				done[wb.tag] <= 1'b1;
			end
			if (cmt_fire) begin
				head <= head + 1'b1;
			end
		end
	end

	// payload capture
	always_ff @(posedge clk) begin
		if (alloc) begin
			ent[alloc_tag].pc <= alloc_uop.pc;
			ent[alloc_tag].rd <= alloc_uop.rd;
			ent[alloc_tag].has_rd <= alloc_uop.has_rd;
			ent[alloc_tag].tag <= alloc_tag;
		end
	end

endmodule

`default_nettype wire

//--- hdl/issue_queue.sv
`default_nettype none

`include "core_defs.svh"

module issue_queue (
	input logic clk,
	input logic rst,
	input logic alloc,
	input uop_pkg::uop_t alloc_uop,
	input uop_pkg::rob_tag_t alloc_tag,
	input uop_pkg::wb_t wb,
	input logic flush,
	output logic iss_valid,
	output uop_pkg::iss_t iss,
	input logic iss_ready,
	output logic full
);
	import uop_pkg::*;

	localparam int DEPTH = `IQ_DEPTH;
	localparam int IDX_W = $clog2(DEPTH);

	typedef logic [IDX_W-1:0] idx_t;

	// slot state
	logic [DEPTH-1:0] valid;
	uop_t uops [DEPTH];
	rob_tag_t tags [DEPTH];
	// count of younger live slots, unique per live slot
	idx_t age [DEPTH];

	logic [DEPTH-1:0] rdy;
	logic sel_found;
	idx_t sel_idx;
	idx_t sel_age;
	// selection held while execute back-pressures
	logic lock;
	idx_t lock_idx;
	idx_t iss_idx;
	idx_t free_idx;
	logic iss_fire;
	uop_t in_woken;

	// clear busy when the broadcast tag matches the producer
	function automatic src_t wake(src_t s, wb_t w);
		src_t r;
		r = s;
		if (w.valid && (w.tag == s.tag)) begin
			r.busy = 1'b0;
		end
		return r;
	endfunction

	// entering uop sees a same-cycle writeback too
	always_comb begin
		in_woken = alloc_uop;
		in_woken.src1 = wake(alloc_uop.src1, wb);
		in_woken.src2 = wake(alloc_uop.src2, wb);
	end

	always_comb begin
		for (int i = 0; i < DEPTH; i++) begin
			rdy[i] = valid[i] & ~uops[i].src1.busy & ~uops[i].src2.busy;
		end
	end

	// oldest ready slot wins
	always_comb begin
		sel_found = 1'b0;
		sel_idx = '0;
		sel_age = '0;
		for (int i = 0; i < DEPTH; i++) begin
			if (rdy[i] && (!sel_found || (age[i] > sel_age))) begin
				sel_found = 1'b1;
				sel_idx = idx_t'(i);
				sel_age = age[i];
			end
		end
	end

	// lowest free slot takes the next allocation
	always_comb begin
		free_idx = '0;
		for (int i = DEPTH - 1; i >= 0; i--) begin
			if (!valid[i]) begin
				free_idx = idx_t'(i);
			end
		end
	end

	// a locked slot stays ready since busy bits only ever clear
	assign iss_idx = lock ? lock_idx : sel_idx;
	assign iss_valid = lock | sel_found;
	assign iss.uop = uops[iss_idx];
	assign iss.tag = tags[iss_idx];
	assign iss_fire = iss_valid & iss_ready;
	assign full = &valid;

	always_ff @(posedge clk) begin
		if (rst || flush) begin
			valid <= '0;
			lock <= 1'b0;
			lock_idx <= '0;
			for (int i = 0; i < DEPTH; i++) begin
				age[i] <= '0;
			end
		end else begin
			// older slots lose the issued one from their younger count
			for (int i = 0; i < DEPTH; i++) begin
				if (valid[i]) begin
					age[i] <= age[i] + idx_t'(alloc)
						- idx_t'(iss_fire && (age[i] > age[iss_idx]));
				end
			end
			if (iss_fire) begin
				valid[iss_idx] <= 1'b0;
			end
			// free_idx is never the issued slot, that one is still valid
			if (alloc) begin
				valid[free_idx] <= 1'b1;
				age[free_idx] <= '0;
			end
			lock <= iss_valid & ~iss_ready;
			lock_idx <= iss_idx;
		end
	end

	// payload with wakeup, allocation overrides its own slot
	always_ff @(posedge clk) begin
		for (int i = 0; i < DEPTH; i++) begin
			uops[i].src1 <= wake(uops[i].src1, wb);
			uops[i].src2 <= wake(uops[i].src2, wb);
		end
		if (alloc) begin
			uops[free_idx] <= in_woken;
			tags[free_idx] <= alloc_tag;
		end
	end

endmodule

`default_nettype wire

//--- hdl/hazard.sv
`default_nettype none

module hazard (
	// instruction memory has returned data
	input logic i_data_ok,
	// predecode found a bad fetch, squash everything in flight
	input logic pd_fail,
	input pipe_ctl_pkg::struct_stat_t stat,
	output pipe_ctl_pkg::pipe_ctl_t ctl,
	output logic in_ready
);
	import pipe_ctl_pkg::*;

	logic busy;
	pipe_ctl_t c;

	// either back end structure out of room
	assign busy = stat.rob_full | stat.iq_full;

	always_comb begin
		c = '0;
		// fetch waits on imem or a full back end
		c.stall_f = ~i_data_ok | busy;
		// decode and rename also freeze while the flush is applied
		c.stall_d = busy | pd_fail;
		c.stall_r = busy | pd_fail;
		// bubble into decode when fetch has nothing
		c.flush_d = ~i_data_ok | pd_fail;
		c.flush_r = pd_fail;
		// rob and issue queue emptied together
		c.flush_q = pd_fail;
	end

	assign ctl = c;
	// rename hands over only when it is not stalled
	assign in_ready = ~c.stall_r;

endmodule

`default_nettype wire

//--- hdl/dispatch_top.sv
`default_nettype none

module dispatch_top (
	input logic clk,
	input logic rst,
	// renamed uops from the front end
	input logic in_valid,
	input uop_pkg::uop_t in_uop,
	output logic in_ready,
	input logic i_data_ok,
	input logic pd_fail,
	// execute port
	output logic iss_valid,
	output uop_pkg::iss_t iss,
	input logic iss_ready,
	// writeback broadcast from execute
	input uop_pkg::wb_t wb,
	// retire port
	output logic cmt_valid,
	output uop_pkg::commit_t cmt,
	input logic cmt_ready,
	output pipe_ctl_pkg::pipe_ctl_t ctl
);
	import uop_pkg::*;
	import pipe_ctl_pkg::*;

	// accepted beat, seen by both structures at once
	logic alloc;
	rob_tag_t alloc_tag;
	struct_stat_t stat;

	assign alloc = in_valid & in_ready;

	// tag source for every dispatched uop
	reorder_buffer u_rob (
		.clk(clk),
		.rst(rst),
		.alloc(alloc),
		.alloc_uop(in_uop),
		.alloc_tag(alloc_tag),
		.wb(wb),
		.flush(ctl.flush_q),
		.cmt_valid(cmt_valid),
		.cmt(cmt),
		.cmt_ready(cmt_ready),
		.full(stat.rob_full)
	);

	// holds the uop with its rob tag until operands are woken
	issue_queue u_iq (
		.clk(clk),
		.rst(rst),
		.alloc(alloc),
		.alloc_uop(in_uop),
		.alloc_tag(alloc_tag),
		.wb(wb),
		.flush(ctl.flush_q),
		.iss_valid(iss_valid),
		.iss(iss),
		.iss_ready(iss_ready),
		.full(stat.iq_full)
	);

	hazard u_hazard (
		.i_data_ok(i_data_ok),
		.pd_fail(pd_fail),
		.stat(stat),
		.ctl(ctl),
		.in_ready(in_ready)
	);

endmodule

`default_nettype wire

//--- bench/dispatch_chk.sv
`default_nettype none

module dispatch_chk (
	input logic clk,
	input logic rst,
	input logic pd_fail,
	input logic in_ready,
	input logic iss_valid,
	input uop_pkg::iss_t iss,
	input logic iss_ready,
	input logic cmt_valid,
	input uop_pkg::commit_t cmt,
	input logic cmt_ready
);
	// bumped on each failed assertion
	int fail_count = 0;

	// execute payload holds under back-pressure, a flush may still drop it
	assert property (@(posedge clk) disable iff (rst)
		iss_valid && !iss_ready && !pd_fail |=> iss_valid && $stable(iss))
	else begin
		fail_count++;
		$error("iss changed or dropped while iss_ready was low");
	end

	// retire payload, same rule
	assert property (@(posedge clk) disable iff (rst)
		cmt_valid && !cmt_ready && !pd_fail |=> cmt_valid && $stable(cmt))
	else begin
		fail_count++;
		$error("cmt changed or dropped while cmt_ready was low");
	end

	// nothing enters while the flush is applied
	assert property (@(posedge clk) disable iff (rst) pd_fail |-> !in_ready)
	else begin
		fail_count++;
		$error("in_ready high during pd_fail");
	end

	// both structures empty right after the flush edge
	assert property (@(posedge clk) disable iff (rst) pd_fail |=> !iss_valid && !cmt_valid)
	else begin
		fail_count++;
		$error("iss_valid or cmt_valid high the cycle after pd_fail");
	end

endmodule

bind dispatch_top dispatch_chk u_chk (.*);

`default_nettype wire

//--- bench/dispatch_tb.sv
`default_nettype none

`include "core_defs.svh"

module dispatch_tb;
	import uop_pkg::*;
	import pipe_ctl_pkg::*;

	// reference entry in dispatch order
	typedef struct packed {
		uop_t uop;
		rob_tag_t tag;
		logic issued;
		logic done;
	} ref_ent_t;

	// execute model entry, tag and the cycle its writeback is due
	typedef struct packed {
		rob_tag_t tag;
		logic [31:0] due;
	} exec_ent_t;

	logic clk;
	logic rst;
	logic in_valid;
	uop_t in_uop;
	logic in_ready;
	logic i_data_ok;
	logic pd_fail;
	logic iss_valid;
	iss_t iss;
	logic iss_ready;
	wb_t wb;
	logic cmt_valid;
	commit_t cmt;
	logic cmt_ready;
	pipe_ctl_t ctl;

	logic [31:0] lfsr;
	logic [31:0] pc_next = 32'h0000_1000;
	int cycle = 0;
	int n_err = 0;
	int n_acc = 0;
	int n_iss = 0;
	int n_cmt = 0;
	// stalls the execute model so producers stay pending
	logic hold_wb = 1'b0;
	rob_tag_t ref_tail = '0;
	ref_ent_t rq[$];
	exec_ent_t xq[$];

	dispatch_top uut (.*);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {1'b0, s[31:1]} ^ (s[0] ? 32'h8020_0003 : 32'h0);
	endfunction

	// one lfsr step per bit
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[30:0], lfsr[0]};
			lfsr = lfsr_step(lfsr);
		end
		return v;
	endfunction

	// busy only toward a live older entry that has not written back
	function automatic src_t pick_src(input logic use_deps);
		src_t s;
		int k;
		s.busy = 1'b0;
		s.tag = rob_tag_t'(rand_bits(3));
		if (use_deps && rq.size() > 0 && rand_bits(1) == 1) begin
			k = int'(rand_bits(4)) % rq.size();
			if (!rq[k].done) begin
				s.busy = 1'b1;
				s.tag = rq[k].tag;
			end
		end
		return s;
	endfunction

	function automatic uop_t make_uop(input logic use_deps);
		uop_t u;
		u.pc = pc_next;
		u.rd = areg_t'(rand_bits(5));
		u.has_rd = 1'(rand_bits(1));
		u.src1 = pick_src(use_deps);
		u.src2 = pick_src(use_deps);
		u.op = 8'(rand_bits(8));
		pc_next = pc_next + 32'd4;
		return u;
	endfunction

	// expected retire payload is the oldest dispatched uop
	function automatic commit_t expected_commit();
		commit_t c;
		c.pc = rq[0].uop.pc;
		c.rd = rq[0].uop.rd;
		c.has_rd = rq[0].uop.has_rd;
		c.tag = rq[0].tag;
		return c;
	endfunction

	// stall and flush rules from the front-end status and reference occupancy
	function automatic pipe_ctl_t expected_ctl(input logic data_ok, input logic pdf,
		input logic rob_full, input logic iq_full);
		pipe_ctl_t c;
		c.stall_f = !data_ok || rob_full || iq_full;
		c.stall_d = rob_full || iq_full || pdf;
		c.stall_r = rob_full || iq_full || pdf;
		c.flush_d = !data_ok || pdf;
		c.flush_r = pdf;
		c.flush_q = pdf;
		return c;
	endfunction

	// live, not yet issued entry with this tag
	function automatic int find_entry(input rob_tag_t t);
		for (int i = 0; i < rq.size(); i++) begin
			if (rq[i].tag == t && !rq[i].issued) begin
				return i;
			end
		end
		return -1;
	endfunction

	// writeback marks the producer done and wakes matching sources
	function automatic void apply_wb(input rob_tag_t t);
		for (int i = 0; i < rq.size(); i++) begin
			if (rq[i].tag == t) begin
				rq[i].done = 1'b1;
			end
			if (rq[i].uop.src1.tag == t) begin
				rq[i].uop.src1.busy = 1'b0;
			end
			if (rq[i].uop.src2.tag == t) begin
				rq[i].uop.src2.busy = 1'b0;
			end
		end
	endfunction

	task automatic report_mismatch(input string sig, input logic [63:0] got,
		input logic [63:0] exp);
		n_err++;
		$display("Fail t=%0t %s got %h expected %h", $time, sig, got, exp);
	endtask

	task automatic report_error(input string what);
		n_err++;
		$display("error at t=%0t: %s", $time, what);
	endtask

	task automatic report_timeout(input string why);
		n_err++;
		$display("timeout at t=%0t: %s", $time, why);
	endtask

	// falling edge, then the execute model broadcasts one due tag
	task automatic next_cycle();
		logic found;
		@(negedge clk);
		cycle++;
		found = 1'b0;
		wb = '0;
		if (!hold_wb) begin
			for (int i = 0; i < xq.size(); i++) begin
				if (!found && xq[i].due <= cycle) begin
					found = 1'b1;
					wb.valid = 1'b1;
					wb.tag = xq[i].tag;
					xq.delete(i);
				end
			end
		end
	endtask

	task automatic send_uop(input uop_t u);
		int start;
		int t;
		start = n_acc;
		t = 0;
		in_valid = 1'b1;
		in_uop = u;
		while (n_acc == start) begin
			next_cycle();
			t++;
			if (t > 100) begin
				report_timeout("uop never accepted");
				break;
			end
		end
		in_valid = 1'b0;
	endtask

	task automatic random_run(input int n);
		for (int i = 0; i < n; i++) begin
			next_cycle();
			in_valid = rand_bits(2) != 0;
			in_uop = make_uop(1'b1);
			iss_ready = rand_bits(2) != 0;
			cmt_ready = rand_bits(2) != 0;
		end
	endtask

	task automatic drain();
		int t;
		t = 0;
		in_valid = 1'b0;
		iss_ready = 1'b1;
		cmt_ready = 1'b1;
		while (rq.size() != 0) begin
			next_cycle();
			t++;
			if (t > 500) begin
				report_timeout("reorder buffer did not drain");
				break;
			end
		end
	endtask

	// compare process, all transfers seen at the rising edge
	always @(posedge clk) begin
		int k;
		int n_wait;
		commit_t exp_c;
		pipe_ctl_t exp_ctl;
		if (!rst) begin
			// occupancy before this edge's transfers
			n_wait = 0;
			for (int i = 0; i < rq.size(); i++) begin
				if (!rq[i].issued) begin
					n_wait++;
				end
			end
			exp_ctl = expected_ctl(i_data_ok, pd_fail, rq.size() == `ROB_DEPTH,
				n_wait == `IQ_DEPTH);
			if (ctl !== exp_ctl) begin
				report_mismatch("ctl", ctl, exp_ctl);
			end
			if (in_ready !== !exp_ctl.stall_r) begin
				report_mismatch("in_ready", in_ready, !exp_ctl.stall_r);
			end
			if (iss_valid && iss_ready) begin
				n_iss++;
				k = find_entry(iss.tag);
				if (k < 0) begin
					report_error($sformatf("tag %0d issued without a pending dispatch", iss.tag));
				end else begin
					if (iss.uop !== rq[k].uop) begin
						report_mismatch("iss.uop", iss.uop, rq[k].uop);
					end
					if (rq[k].uop.src1.busy || rq[k].uop.src2.busy) begin
						report_error($sformatf("tag %0d issued before its producer", iss.tag));
					end
					rq[k].issued = 1'b1;
					xq.push_back(exec_ent_t'{tag: iss.tag, due: cycle + 1 + rand_bits(3)});
				end
			end
			if (cmt_valid && cmt_ready) begin
				n_cmt++;
				if (rq.size() == 0) begin
					report_error("commit with nothing dispatched");
				end else begin
					exp_c = expected_commit();
					if (cmt.pc !== exp_c.pc) begin
						report_mismatch("cmt.pc", cmt.pc, exp_c.pc);
					end
					if (cmt.rd !== exp_c.rd) begin
						report_mismatch("cmt.rd", cmt.rd, exp_c.rd);
					end
					if (cmt.has_rd !== exp_c.has_rd) begin
						report_mismatch("cmt.has_rd", cmt.has_rd, exp_c.has_rd);
					end
					if (cmt.tag !== exp_c.tag) begin
						report_mismatch("cmt.tag", cmt.tag, exp_c.tag);
					end
					if (!rq[0].done) begin
						report_error("commit of an entry that never wrote back");
					end
					void'(rq.pop_front());
				end
			end
			if (in_valid && in_ready) begin
				n_acc++;
				rq.push_back(ref_ent_t'{uop: in_uop, tag: ref_tail, issued: 1'b0, done: 1'b0});
				ref_tail = ref_tail + 1'b1;
			end
			if (wb.valid) begin
				apply_wb(wb.tag);
			end
			// predecode failure empties everything in flight
			if (pd_fail) begin
				rq.delete();
				xq.delete();
				ref_tail = '0;
			end
		end
	end

	initial begin
		int acc0;
		int iss0;
		int cmt0;
		int t;
		uop_t u;
		rob_tag_t p;
		lfsr = 32'h6b46_259a;
		rst = 1'b1;
		in_valid = 1'b0;
		in_uop = '0;
		i_data_ok = 1'b1;
		pd_fail = 1'b0;
		iss_ready = 1'b0;
		cmt_ready = 1'b0;
		wb = '0;
		repeat (8) next_cycle();
		rst = 1'b0;
		next_cycle();
		if (iss_valid !== 1'b0) begin
			report_mismatch("iss_valid", iss_valid, 0);
		end
		if (cmt_valid !== 1'b0) begin
			report_mismatch("cmt_valid", cmt_valid, 0);
		end

		// random traffic with dependencies and back-pressure
		random_run(600);
		drain();

		// rob fills while retire is blocked
		cmt_ready = 1'b0;
		for (int i = 0; i < `ROB_DEPTH; i++) begin
			send_uop(make_uop(1'b0));
		end
		if (in_ready !== 1'b0) begin
			report_mismatch("in_ready", in_ready, 0);
		end
		if (ctl.stall_f !== 1'b1) begin
			report_mismatch("ctl.stall_f", ctl.stall_f, 1);
		end
		acc0 = n_acc;
		in_valid = 1'b1;
		in_uop = make_uop(1'b0);
		repeat (3) next_cycle();
		if (n_acc != acc0) begin
			report_error("uop accepted into a full reorder buffer");
		end
		drain();

		// issue queue fills with uops waiting on one held producer
		hold_wb = 1'b1;
		send_uop(make_uop(1'b0));
		p = rq[rq.size() - 1].tag;
		for (int i = 0; i < `IQ_DEPTH; i++) begin
			u = make_uop(1'b0);
			u.src1.busy = 1'b1;
			u.src1.tag = p;
			send_uop(u);
		end
		iss0 = n_iss;
		repeat (4) begin
			next_cycle();
			if (in_ready !== 1'b0) begin
				report_mismatch("in_ready", in_ready, 0);
			end
		end
		hold_wb = 1'b0;
		t = 0;
		while (n_iss == iss0) begin
			if (in_ready !== 1'b0) begin
				report_mismatch("in_ready", in_ready, 0);
			end
			next_cycle();
			t++;
			if (t > 50) begin
				report_timeout("blocked uops never issued");
				break;
			end
		end
		if (in_ready !== 1'b1) begin
			report_mismatch("in_ready", in_ready, 1);
		end
		drain();

		// imem not ready
		i_data_ok = 1'b0;
		next_cycle();
		if (ctl.stall_f !== 1'b1) begin
			report_mismatch("ctl.stall_f", ctl.stall_f, 1);
		end
		if (ctl.flush_d !== 1'b1) begin
			report_mismatch("ctl.flush_d", ctl.flush_d, 1);
		end
		i_data_ok = 1'b1;

		// predecode failure with work in flight
		hold_wb = 1'b1;
		for (int i = 0; i < 3; i++) begin
			send_uop(make_uop(1'b1));
		end
		acc0 = n_acc;
		pd_fail = 1'b1;
		in_valid = 1'b1;
		in_uop = make_uop(1'b0);
		next_cycle();
		pd_fail = 1'b0;
		in_valid = 1'b0;
		hold_wb = 1'b0;
		if (n_acc != acc0) begin
			report_error("uop accepted during pd_fail");
		end
		iss0 = n_iss;
		cmt0 = n_cmt;
		repeat (10) begin
			next_cycle();
			if (iss_valid !== 1'b0) begin
				report_mismatch("iss_valid", iss_valid, 0);
			end
			if (cmt_valid !== 1'b0) begin
				report_mismatch("cmt_valid", cmt_valid, 0);
			end
		end
		if (n_iss != iss0 || n_cmt != cmt0) begin
			report_error("issue or commit after pd_fail with nothing dispatched");
		end

		// traffic resumes after the flush
		random_run(300);
		drain();

		$display("errors %0d, assertion failures %0d, dispatched %0d, issued %0d, committed %0d",
			n_err, uut.u_chk.fail_count, n_acc, n_iss, n_cmt);
		if (n_err == 0 && uut.u_chk.fail_count == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- files.f
+incdir+hdl
hdl/uop_pkg.sv
hdl/pipe_ctl_pkg.sv
hdl/reorder_buffer.sv
hdl/issue_queue.sv
hdl/hazard.sv
hdl/dispatch_top.sv
bench/dispatch_chk.sv
bench/dispatch_tb.sv

//--- Bender.yml
package:
  name: dispatch_backend

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/uop_pkg.sv
      - hdl/pipe_ctl_pkg.sv
      - hdl/reorder_buffer.sv
      - hdl/issue_queue.sv
      - hdl/hazard.sv
      - hdl/dispatch_top.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - bench/dispatch_chk.sv
      - bench/dispatch_tb.sv
